// File: build.f
+incdir+src
+incdir+test
src/id_pkg.sv
src/id_fetch_latch.sv
src/id_operand_bypass.sv
src/id_decoder.sv
src/id_branch_unit.sv
src/id_stage.sv
test/tb_id_stage.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_id_stage -f build.f

./obj_dir/Vtb_id_stage > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0

// File: src/id_branch_unit.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module id_branch_unit
    import id_pkg::*;
(
    input  logic [`ID_XLEN-1:0] id_pc,
    input  logic [`ID_XLEN-1:0] id_inst,
    input  br_kind_t            br_kind,
    input  logic [`ID_XLEN-1:0] rs_data,
    input  logic [`ID_XLEN-1:0] rt_data,
    output logic                br_taken,
    output logic [`ID_XLEN-1:0] br_target
);

    logic [`ID_XLEN-1:0]  base;
    logic [`ID_IMM_W-1:0] offset;
    logic [`ID_XLEN-1:0]  rel_target;
    logic [`ID_XLEN-1:0]  abs_target;
    logic                 rs_eq_rt;

    // targets are relative to the delay slot
    assign base       = id_pc + `ID_XLEN'(`ID_PC_STEP);
    assign offset     = id_inst[`ID_IMM_W-1:0];
    assign rel_target = base + {{(`ID_XLEN - `ID_IMM_W - 2){offset[`ID_IMM_W-1]}}, offset, 2'b00};
    assign abs_target = {base[31:28], id_inst[25:0], 2'b00};
    assign rs_eq_rt   = (rs_data == rt_data);

    always_comb begin
        case (br_kind)
            BR_BEQ:        br_taken = rs_eq_rt;
            BR_BNE:        br_taken = !rs_eq_rt;
            BR_J, BR_JAL:  br_taken = 1'b1;
            BR_JR:         br_taken = 1'b1;
            default:       br_taken = 1'b0;
        endcase
        br_target = '0;
        if (br_taken) begin
            case (br_kind)
                BR_J, BR_JAL: br_target = abs_target;
                BR_JR:        br_target = rs_data;
                default:      br_target = rel_target;
            endcase
        end
    end

endmodule

// File: src/id_consts.svh
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// datapath and address width
`define ID_XLEN 32

// register file geometry
`define ID_REG_AW 5
`define ID_NUM_REGS 32

// immediate field of I-type instructions
`define ID_IMM_W 16

// jal writes its return address here
`define ID_LINK_REG 31

// sequential fetch step in bytes
`define ID_PC_STEP 4

`endif

// File: src/id_decoder.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module id_decoder
    import id_pkg::*;
(
    input  logic                  id_valid,
    input  logic [`ID_XLEN-1:0]   id_inst,
    output alu_op_t               alu_op,
    output src1_sel_t             src1_sel,
    output src2_sel_t             src2_sel,
    output logic                  mem_en,
    output logic                  mem_we,
    output logic                  rf_we,
    output logic [`ID_REG_AW-1:0] rf_waddr,
    output logic                  sel_rf_res,
    output br_kind_t              br_kind
);

    opcode_t               opcode;
    funct_t                funct;
    logic [`ID_REG_AW-1:0] rt;
    logic [`ID_REG_AW-1:0] rd;
    // which destination field the instruction writes
    logic                  wr_rd;
    logic                  wr_rt;
    logic                  wr_link;

    assign opcode = opcode_t'(id_inst[31:26]);
    assign funct  = funct_t'(id_inst[5:0]);
    assign rt     = id_inst[20:16];
    assign rd     = id_inst[15:11];

    always_comb begin
        alu_op     = ALU_NONE;
        src1_sel   = SRC1_RS;
        src2_sel   = SRC2_RT;
        mem_en     = 1'b0;
        mem_we     = 1'b0;
        sel_rf_res = 1'b0;
        br_kind    = BR_NONE;
        wr_rd      = 1'b0;
        wr_rt      = 1'b0;
        wr_link    = 1'b0;
        if (id_valid) begin
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        FN_ADDU: alu_op = ALU_ADD;
                        FN_SUBU: alu_op = ALU_SUB;
                        FN_SLT:  alu_op = ALU_SLT;
                        FN_SLTU: alu_op = ALU_SLTU;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_XOR:  alu_op = ALU_XOR;
                        FN_NOR:  alu_op = ALU_NOR;
                        FN_SLLV: alu_op = ALU_SLL;
                        FN_SRLV: alu_op = ALU_SRL;
                        FN_SRAV: alu_op = ALU_SRA;
                        FN_JR:   br_kind = BR_JR;
                        default: ;
                    endcase
                    // fixed shifts take the amount from the sa field
                    case (funct)
                        FN_SLL:  alu_op = ALU_SLL;
                        FN_SRL:  alu_op = ALU_SRL;
                        FN_SRA:  alu_op = ALU_SRA;
                        default: ;
                    endcase
                    if (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA) begin
                        src1_sel = SRC1_SA;
                    end
                    wr_rd = (alu_op != ALU_NONE);
                end
                OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI, OP_LW, OP_SW: begin
                    src2_sel = SRC2_IMM_SEXT;
                    case (opcode)
                        OP_SLTI:  alu_op = ALU_SLT;
                        OP_SLTIU: alu_op = ALU_SLTU;
                        OP_LUI:   alu_op = ALU_LUI;
                        default:  alu_op = ALU_ADD;
                    endcase
                    mem_en     = (opcode == OP_LW || opcode == OP_SW);
                    mem_we     = (opcode == OP_SW);
                    sel_rf_res = (opcode == OP_LW);
                    wr_rt      = (opcode != OP_SW);
                end
                OP_ANDI, OP_ORI, OP_XORI: begin
                    src2_sel = SRC2_IMM_ZEXT;
                    case (opcode)
                        OP_ANDI: alu_op = ALU_AND;
                        OP_ORI:  alu_op = ALU_OR;
                        default: alu_op = ALU_XOR;
                    endcase
                    wr_rt = 1'b1;
                end
                OP_BEQ: br_kind = BR_BEQ;
                OP_BNE: br_kind = BR_BNE;
                OP_J:   br_kind = BR_J;
                OP_JAL: begin
                    // return address is pc + 8, past the delay slot
                    br_kind  = BR_JAL;
                    alu_op   = ALU_ADD;
                    src1_sel = SRC1_PC;
                    src2_sel = SRC2_CONST8;
                    wr_link  = 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign rf_we    = wr_rd || wr_rt || wr_link;
    assign rf_waddr = wr_link ? `ID_REG_AW'(`ID_LINK_REG) :
                      wr_rt   ? rt :
                      wr_rd   ? rd : '0;

    // a store never writes the register file
    always_comb begin
        assert (!mem_we || (mem_en && !rf_we));
    end

endmodule

// File: src/id_fetch_latch.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module id_fetch_latch (
    input  logic                clk,
    input  logic                rst,
    input  logic [`ID_XLEN-1:0] if_pc,
    input  logic                if_valid,
    input  logic [`ID_XLEN-1:0] inst_sram_rdata,
    input  logic                stall_fetch,
    input  logic                stall_decode,
    output logic                id_valid,
    output logic [`ID_XLEN-1:0] id_pc,
    output logic [`ID_XLEN-1:0] id_inst
);

    logic                valid_q;
    logic [`ID_XLEN-1:0] pc_q;
    // set once the sram word has been parked during a full stall
    logic                hold_q;
    logic [`ID_XLEN-1:0] held_inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            hold_q  <= 1'b0;
        end else if (!stall_fetch) begin
            valid_q <= if_valid;
            pc_q    <= if_pc;
            hold_q  <= 1'b0;
        end else if (!stall_decode) begin
            // fetch stopped but decode moves on, so push a bubble
            valid_q <= 1'b0;
            hold_q  <= 1'b0;
        end else if (!hold_q) begin
            hold_q <= 1'b1;
        end
    end

    // the sram only shows the word for one cycle, keep a copy
    always_ff @(posedge clk) begin
        if (stall_fetch && stall_decode && !hold_q) begin
            held_inst <= inst_sram_rdata;
        end
    end

    assign id_valid = valid_q;
    assign id_pc    = pc_q;
    assign id_inst  = !valid_q ? '0 : (hold_q ? held_inst : inst_sram_rdata);

    hold_needs_fetch_stall: assert property (
        @(posedge clk) disable iff (rst) !stall_fetch |=> !hold_q
    );

endmodule

// File: src/id_operand_bypass.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module id_operand_bypass (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  logic [`ID_XLEN-1:0]   id_inst,
    input  logic                  ex_rf_we,
    input  logic [`ID_REG_AW-1:0] ex_rf_waddr,
    input  logic [`ID_XLEN-1:0]   ex_rf_wdata,
    input  logic                  ex_is_load,
    input  logic                  mem_rf_we,
    input  logic [`ID_REG_AW-1:0] mem_rf_waddr,
    input  logic [`ID_XLEN-1:0]   mem_rf_wdata,
    input  logic                  wb_rf_we,
    input  logic [`ID_REG_AW-1:0] wb_rf_waddr,
    input  logic [`ID_XLEN-1:0]   wb_rf_wdata,
    output logic [`ID_XLEN-1:0]   rs_data,
    output logic [`ID_XLEN-1:0]   rt_data,
    output logic                  stallreq
);

    logic [`ID_XLEN-1:0]   regs [`ID_NUM_REGS];
    logic [`ID_REG_AW-1:0] rs;
    logic [`ID_REG_AW-1:0] rt;

    assign rs = id_inst[25:21];
    assign rt = id_inst[20:16];

    // write-back port, register 0 stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ID_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_rf_we && wb_rf_waddr != '0) begin
            regs[wb_rf_waddr] <= wb_rf_wdata;
        end
    end

    // youngest producer wins: execute, then memory, then write-back
    function automatic logic [`ID_XLEN-1:0] bypass(
        input logic [`ID_REG_AW-1:0] addr,
        input logic [`ID_XLEN-1:0]   file_val
    );
        logic [`ID_XLEN-1:0] val;
        val = file_val;
        if (addr != '0) begin
            if (ex_rf_we && ex_rf_waddr == addr) begin
                val = ex_rf_wdata;
            end else if (mem_rf_we && mem_rf_waddr == addr) begin
                val = mem_rf_wdata;
            end else if (wb_rf_we && wb_rf_waddr == addr) begin
                val = wb_rf_wdata;
            end
        end
        return val;
    endfunction

    always_comb begin
        rs_data = bypass(rs, regs[rs]);
        rt_data = bypass(rt, regs[rt]);
    end

    // load data is not ready until memory, so the consumer has to wait
    assign stallreq = id_valid && ex_is_load && ex_rf_we && ex_rf_waddr != '0 &&
                      (ex_rf_waddr == rs || ex_rf_waddr == rt);

    zero_reg_reads_zero: assert property (
        @(posedge clk) disable iff (rst) (rs == '0) |-> (rs_data == '0)
    );

endmodule

// File: src/id_pkg.sv
package id_pkg;

    // primary opcodes, SPECIAL carries the function code
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function codes under SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // SA is the zero-extended shift amount field
    typedef enum logic [1:0] {
        SRC1_RS, SRC1_PC, SRC1_SA
    } src1_sel_t;

    // CONST8 feeds the jal return address computation
    typedef enum logic [1:0] {
        SRC2_RT, SRC2_IMM_SEXT, SRC2_IMM_ZEXT, SRC2_CONST8
    } src2_sel_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR
    } br_kind_t;

endpackage

// File: src/id_stage.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module id_stage
    import id_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ID_XLEN-1:0]   if_pc,
    input  logic                  if_valid,
    input  logic [`ID_XLEN-1:0]   inst_sram_rdata,
    input  logic                  stall_fetch,
    input  logic                  stall_decode,
    input  logic                  ex_rf_we,
    input  logic [`ID_REG_AW-1:0] ex_rf_waddr,
    input  logic [`ID_XLEN-1:0]   ex_rf_wdata,
    input  logic                  ex_is_load,
    input  logic                  mem_rf_we,
    input  logic [`ID_REG_AW-1:0] mem_rf_waddr,
    input  logic [`ID_XLEN-1:0]   mem_rf_wdata,
    input  logic                  wb_rf_we,
    input  logic [`ID_REG_AW-1:0] wb_rf_waddr,
    input  logic [`ID_XLEN-1:0]   wb_rf_wdata,
    output logic                  id_valid,
    output logic [`ID_XLEN-1:0]   id_pc,
    output logic [`ID_XLEN-1:0]   id_inst,
    output alu_op_t               alu_op,
    output src1_sel_t             src1_sel,
    output src2_sel_t             src2_sel,
    output logic                  mem_en,
    output logic                  mem_we,
    output logic                  rf_we,
    output logic [`ID_REG_AW-1:0] rf_waddr,
    output logic                  sel_rf_res,
    output logic [`ID_XLEN-1:0]   rs_data,
    output logic [`ID_XLEN-1:0]   rt_data,
    output logic                  br_taken,
    output logic [`ID_XLEN-1:0]   br_target,
    output logic                  stallreq
);

    br_kind_t br_kind;

    id_fetch_latch u_fetch_latch (
        .clk             (clk),
        .rst             (rst),
        .if_pc           (if_pc),
        .if_valid        (if_valid),
        .inst_sram_rdata (inst_sram_rdata),
        .stall_fetch     (stall_fetch),
        .stall_decode    (stall_decode),
        .id_valid        (id_valid),
        .id_pc           (id_pc),
        .id_inst         (id_inst)
    );

    id_operand_bypass u_operand_bypass (
        .clk          (clk),
        .rst          (rst),
        .id_valid     (id_valid),
        .id_inst      (id_inst),
        .ex_rf_we     (ex_rf_we),
        .ex_rf_waddr  (ex_rf_waddr),
        .ex_rf_wdata  (ex_rf_wdata),
        .ex_is_load   (ex_is_load),
        .mem_rf_we    (mem_rf_we),
        .mem_rf_waddr (mem_rf_waddr),
        .mem_rf_wdata (mem_rf_wdata),
        .wb_rf_we     (wb_rf_we),
        .wb_rf_waddr  (wb_rf_waddr),
        .wb_rf_wdata  (wb_rf_wdata),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .stallreq     (stallreq)
    );

    id_decoder u_decoder (
        .id_valid   (id_valid),
        .id_inst    (id_inst),
        .alu_op     (alu_op),
        .src1_sel   (src1_sel),
        .src2_sel   (src2_sel),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .sel_rf_res (sel_rf_res),
        .br_kind    (br_kind)
    );

    id_branch_unit u_branch_unit (
        .id_pc     (id_pc),
        .id_inst   (id_inst),
        .br_kind   (br_kind),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

// File: test/id_tests.svh
task automatic expect_idle();
    check_value("id_valid", 0, 32'(id_valid));
    check_value("rf_we", 0, 32'(rf_we));
    check_value("mem_en", 0, 32'(mem_en));
    check_value("mem_we", 0, 32'(mem_we));
    check_value("br_taken", 0, 32'(br_taken));
    check_value("stallreq", 0, 32'(stallreq));
endtask

task automatic expect_decode(input logic [31:0] inst, input alu_op_t exp_op,
                             input src1_sel_t exp_s1, input src2_sel_t exp_s2,
                             input logic [4:0] exp_waddr);
    load_inst(next_rand() & 32'hffff_fffc, inst);
    check_value("alu_op", 32'(exp_op), 32'(alu_op));
    check_value("src1_sel", 32'(exp_s1), 32'(src1_sel));
    check_value("src2_sel", 32'(exp_s2), 32'(src2_sel));
    check_value("rf_we", 1, 32'(rf_we));
    check_value("rf_waddr", 32'(exp_waddr), 32'(rf_waddr));
endtask

task automatic branch_case(input logic [31:0] pc, input logic [31:0] inst,
                           input logic exp_taken, input logic [31:0] exp_target);
    load_inst(pc, inst);
    check_value("br_taken", 32'(exp_taken), 32'(br_taken));
    check_value("br_target", exp_target, br_target);
endtask

// rst is already high from time zero
task automatic test_reset();
    repeat (4) @(negedge clk);
    expect_idle();
    @(negedge clk);
    rst = 1'b0;
    #10;
    expect_idle();
    @(negedge clk);
    #10;
    expect_idle();
endtask

task automatic test_alu_decode();
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sa;
    logic [15:0] imm;
    rs = pick_reg();
    rt = pick_reg();
    rd = pick_reg();
    sa = 5'(next_rand());
    imm = 16'(next_rand());
    expect_decode(r_type(rs, rt, rd, sa, FN_ADDU), ALU_ADD, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_SUBU), ALU_SUB, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_SLT), ALU_SLT, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_SLTU), ALU_SLTU, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_AND), ALU_AND, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_OR), ALU_OR, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_XOR), ALU_XOR, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_NOR), ALU_NOR, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_SLLV), ALU_SLL, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_SRLV), ALU_SRL, SRC1_RS, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_SRAV), ALU_SRA, SRC1_RS, SRC2_RT, rd);
    // shifts by the sa field
    expect_decode(r_type(rs, rt, rd, sa, FN_SLL), ALU_SLL, SRC1_SA, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_SRL), ALU_SRL, SRC1_SA, SRC2_RT, rd);
    expect_decode(r_type(rs, rt, rd, sa, FN_SRA), ALU_SRA, SRC1_SA, SRC2_RT, rd);
    expect_decode(i_type(OP_ADDIU, rs, rt, imm), ALU_ADD, SRC1_RS, SRC2_IMM_SEXT, rt);
    expect_decode(i_type(OP_SLTI, rs, rt, imm), ALU_SLT, SRC1_RS, SRC2_IMM_SEXT, rt);
    expect_decode(i_type(OP_SLTIU, rs, rt, imm), ALU_SLTU, SRC1_RS, SRC2_IMM_SEXT, rt);
    expect_decode(i_type(OP_ANDI, rs, rt, imm), ALU_AND, SRC1_RS, SRC2_IMM_ZEXT, rt);
    expect_decode(i_type(OP_ORI, rs, rt, imm), ALU_OR, SRC1_RS, SRC2_IMM_ZEXT, rt);
    expect_decode(i_type(OP_XORI, rs, rt, imm), ALU_XOR, SRC1_RS, SRC2_IMM_ZEXT, rt);
    expect_decode(i_type(OP_LUI, rs, rt, imm), ALU_LUI, SRC1_RS, SRC2_IMM_SEXT, rt);
    load_inst(32'h0000_1000, {6'h3f, 26'(next_rand())});
    check_value("alu_op", 32'(ALU_NONE), 32'(alu_op));
    check_value("rf_we", 0, 32'(rf_we));
    check_value("mem_en", 0, 32'(mem_en));
    check_value("mem_we", 0, 32'(mem_we));
    check_value("br_taken", 0, 32'(br_taken));
endtask

task automatic test_forwarding();
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] vx;
    logic [31:0] vm;
    logic [31:0] vw;
    repeat (4) begin
        ra = pick_reg();
        rb = next_reg(ra);
        va = next_rand();
        vb = next_rand();
        write_reg(ra, va);
        write_reg(rb, vb);
        load_inst(32'h0000_2000, r_type(ra, rb, 5'd0, 5'd0, FN_ADDU));
        check_value("rs_data", va, rs_data);
        check_value("rt_data", vb, rt_data);
    end
    // three producers drive one address with distinct values
    vx = next_rand();
    vm = ~vx;
    vw = vx ^ 32'h5a5a_0f0f;
    @(negedge clk);
    ex_rf_we = 1'b1;
    ex_rf_waddr = ra;
    ex_rf_wdata = vx;
    mem_rf_we = 1'b1;
    mem_rf_waddr = ra;
    mem_rf_wdata = vm;
    wb_rf_we = 1'b1;
    wb_rf_waddr = ra;
    wb_rf_wdata = vw;
    #10;
    check_value("rs_data", vx, rs_data);
    @(negedge clk);
    ex_rf_we = 1'b0;
    #10;
    check_value("rs_data", vm, rs_data);
    @(negedge clk);
    mem_rf_we = 1'b0;
    #10;
    check_value("rs_data", vw, rs_data);
    @(negedge clk);
    wb_rf_we = 1'b0;
    #10;
    // the write-back value landed in the file
    check_value("rs_data", vw, rs_data);
    load_inst(32'h0000_2400, r_type(5'd0, rb, 5'd0, 5'd0, FN_ADDU));
    @(negedge clk);
    ex_rf_we = 1'b1;
    ex_rf_waddr = 5'd0;
    wb_rf_we = 1'b1;
    wb_rf_waddr = 5'd0;
    wb_rf_wdata = next_rand() | 32'd1;
    #10;
    check_value("rs_data", 0, rs_data);
    @(negedge clk);
    ex_rf_we = 1'b0;
    wb_rf_we = 1'b0;
    #10;
    check_value("rs_data", 0, rs_data);
endtask

task automatic test_memory_and_hazard();
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  other;
    logic [15:0] imm;
    rs = pick_reg();
    rt = next_reg(rs);
    other = next_reg(rt);
    imm = 16'(next_rand());
    load_inst(32'h0000_3000, i_type(OP_LW, rs, rt, imm));
    check_value("mem_en", 1, 32'(mem_en));
    check_value("mem_we", 0, 32'(mem_we));
    check_value("sel_rf_res", 1, 32'(sel_rf_res));
    check_value("rf_we", 1, 32'(rf_we));
    check_value("rf_waddr", 32'(rt), 32'(rf_waddr));
    check_value("alu_op", 32'(ALU_ADD), 32'(alu_op));
    check_value("src2_sel", 32'(SRC2_IMM_SEXT), 32'(src2_sel));
    // load in execute against each source field
    @(negedge clk);
    ex_is_load = 1'b1;
    ex_rf_we = 1'b1;
    ex_rf_waddr = rs;
    #10;
    check_value("stallreq", 1, 32'(stallreq));
    @(negedge clk);
    ex_rf_waddr = rt;
    #10;
    check_value("stallreq", 1, 32'(stallreq));
    @(negedge clk);
    ex_rf_waddr = other;
    #10;
    check_value("stallreq", 0, 32'(stallreq));
    @(negedge clk);
    ex_is_load = 1'b0;
    ex_rf_we = 1'b0;
    load_inst(32'h0000_3004, i_type(OP_SW, rs, rt, imm));
    check_value("mem_en", 1, 32'(mem_en));
    check_value("mem_we", 1, 32'(mem_we));
    check_value("rf_we", 0, 32'(rf_we));
    check_value("sel_rf_res", 0, 32'(sel_rf_res));
endtask

task automatic test_branches();
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] va;
    logic [31:0] pc;
    logic [31:0] base;
    logic [31:0] rel;
    logic [31:0] jtarget;
    logic [15:0] off;
    logic [25:0] idx;
    ra = pick_reg();
    rb = next_reg(ra);
    va = next_rand();
    write_reg(ra, va);
    write_reg(rb, ~va);
    pc = next_rand() & 32'hffff_fffc;
    off = 16'(next_rand());
    base = pc + 32'd4;
    // word offset counted from the delay slot
    rel = base + (32'($signed(off)) << 2);
    branch_case(pc, i_type(OP_BEQ, ra, ra, off), 1'b1, rel);
    branch_case(pc, i_type(OP_BEQ, ra, rb, off), 1'b0, 0);
    branch_case(pc, i_type(OP_BNE, ra, rb, off), 1'b1, rel);
    branch_case(pc, i_type(OP_BNE, ra, ra, off), 1'b0, 0);
    idx = 26'(next_rand());
    jtarget = (base & 32'hf000_0000) | (32'(idx) << 2);
    branch_case(pc, j_type(OP_J, idx), 1'b1, jtarget);
    branch_case(pc, j_type(OP_JAL, idx), 1'b1, jtarget);
    check_value("rf_we", 1, 32'(rf_we));
    check_value("rf_waddr", 31, 32'(rf_waddr));
    check_value("alu_op", 32'(ALU_ADD), 32'(alu_op));
    check_value("src1_sel", 32'(SRC1_PC), 32'(src1_sel));
    check_value("src2_sel", 32'(SRC2_CONST8), 32'(src2_sel));
    branch_case(pc, r_type(ra, 5'd0, 5'd0, 5'd0, FN_JR), 1'b1, va);
endtask

task automatic test_stall_hold();
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] p1;
    logic [31:0] p2;
    w1 = r_type(pick_reg(), pick_reg(), pick_reg(), 5'd0, FN_ADDU);
    w2 = i_type(OP_ORI, pick_reg(), pick_reg(), 16'(next_rand()));
    p1 = 32'h0000_4000;
    p2 = 32'h0000_4004;
    load_inst(p1, w1);
    @(negedge clk);
    stall_fetch = 1'b1;
    stall_decode = 1'b1;
    if_pc = p2;
    @(negedge clk);
    inst_sram_rdata = w2;
    #10;
    check_value("id_inst", w1, id_inst);
    check_value("id_pc", p1, id_pc);
    check_value("id_valid", 1, 32'(id_valid));
    @(negedge clk);
    #10;
    check_value("id_inst", w1, id_inst);
    // fetch still stopped while decode drains into a bubble
    @(negedge clk);
    stall_decode = 1'b0;
    @(negedge clk);
    #10;
    check_value("id_valid", 0, 32'(id_valid));
    check_value("id_inst", 0, id_inst);
    @(negedge clk);
    stall_fetch = 1'b0;
    @(negedge clk);
    #10;
    check_value("id_valid", 1, 32'(id_valid));
    check_value("id_pc", p2, id_pc);
    check_value("id_inst", w2, id_inst);
endtask

// File: test/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage
    import id_pkg::*;
();

    // generous bound, the directed tests need a few hundred cycles
    localparam int CYCLE_LIMIT = 2000;

    logic        clk;
    logic        rst;
    logic [31:0] if_pc;
    logic        if_valid;
    logic [31:0] inst_sram_rdata;
    logic        stall_fetch;
    logic        stall_decode;
    logic        ex_rf_we;
    logic [4:0]  ex_rf_waddr;
    logic [31:0] ex_rf_wdata;
    logic        ex_is_load;
    logic        mem_rf_we;
    logic [4:0]  mem_rf_waddr;
    logic [31:0] mem_rf_wdata;
    logic        wb_rf_we;
    logic [4:0]  wb_rf_waddr;
    logic [31:0] wb_rf_wdata;
    logic        id_valid;
    logic [31:0] id_pc;
    logic [31:0] id_inst;
    alu_op_t     alu_op;
    src1_sel_t   src1_sel;
    src2_sel_t   src2_sel;
    logic        mem_en;
    logic        mem_we;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic        sel_rf_res;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        br_taken;
    logic [31:0] br_target;
    logic        stallreq;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] seed = 32'ha5b2;

    id_stage uut (.*);

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // any register except r0
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return 5'(r % 31) + 5'd1;
    endfunction

    function automatic logic [4:0] next_reg(input logic [4:0] r);
        return (r == 5'd31) ? 5'd1 : r + 5'd1;
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input funct_t fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(input opcode_t op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input opcode_t op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    // capture pc, then present the word one cycle later like the sram does
    task automatic load_inst(input logic [31:0] pc, input logic [31:0] inst);
        @(negedge clk);
        if_pc = pc;
        if_valid = 1'b1;
        stall_fetch = 1'b0;
        stall_decode = 1'b0;
        @(negedge clk);
        inst_sram_rdata = inst;
        #10;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        wb_rf_we = 1'b1;
        wb_rf_waddr = addr;
        wb_rf_wdata = data;
        @(negedge clk);
        wb_rf_we = 1'b0;
    endtask

    `include "id_tests.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        rst = 1'b1;
        if_pc = '0;
        if_valid = 1'b0;
        inst_sram_rdata = '0;
        stall_fetch = 1'b0;
        stall_decode = 1'b0;
        ex_rf_we = 1'b0;
        ex_rf_waddr = '0;
        ex_rf_wdata = '0;
        ex_is_load = 1'b0;
        mem_rf_we = 1'b0;
        mem_rf_waddr = '0;
        mem_rf_wdata = '0;
        wb_rf_we = 1'b0;
        wb_rf_waddr = '0;
        wb_rf_wdata = '0;
        test_reset();
        test_alu_decode();
        test_forwarding();
        test_memory_and_hazard();
        test_branches();
        test_stall_hold();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
